//--- src/eth_pkg.sv
package eth_pkg;

  // CRC-32 (IEEE 802.3) generator polynomial, non-reflected form
  localparam logic [31:0] crc_poly = 32'h04C11DB7;

  // payload geometry
  localparam int max_words  = 16;
  localparam int word_idx_w = 4;
  localparam int len_w      = 5;
  // bit index across payload plus CRC word, up to 17 words
  localparam int bit_cnt_w  = 10;

  // medium access timing
  localparam int ifg_cycles    = 16;
  localparam int ifg_w         = 5;
  localparam int slot_cycles   = 8;
  localparam int max_attempts  = 16;
  localparam int att_w         = 5;
  localparam int backoff_limit = 10;
  // wide enough for (2**backoff_limit - 1) * slot_cycles
  localparam int backoff_w     = 13;

  // APB register map
  localparam logic [7:0] addr_ctrl      = 8'h00;
  localparam logic [7:0] addr_status    = 8'h04;
  localparam logic [7:0] addr_rx_len    = 8'h08;
  localparam logic [7:0] addr_data_base = 8'h40;

  typedef struct packed {
    logic             start;
    logic [len_w-1:0] len_words;
  } tx_req_t;

  typedef struct packed {
    logic             busy;
    logic             done;
    logic             abandoned;
    logic [att_w-1:0] attempts;
  } tx_status_t;

  typedef struct packed {
    logic             done;
    logic             crc_ok;
    logic [len_w-1:0] len_words;
  } rx_status_t;

  // one serial wire with its enable, en doubles as carrier on receive
  typedef struct packed {
    logic data;
    logic en;
  } line_t;

endpackage

//--- src/crc32_engine.sv
`timescale 1ns/100ps

module crc32_engine
  import eth_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  logic        bit_in,
  input  logic        write,
  input  logic        term,
  output logic        done,
  output logic [31:0] crc
);

  logic [31:0] crc_reg;
  logic [5:0]  flush_cnt;
  logic        terminal;
  logic        shift_en;
  logic        shift_bit;
  logic [31:0] feedback;

  // data bits go in until term, then 32 zero bits flush the augmented register
  assign shift_en  = terminal ? (flush_cnt != 6'd0) : write;
  assign shift_bit = terminal ? 1'b0 : bit_in;
  assign feedback  = crc_reg[31] ? crc_poly : 32'h0;
  assign crc       = ~crc_reg;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      crc_reg   <= 32'h0;
      flush_cnt <= 6'd0;
      terminal  <= 1'b0;
      done      <= 1'b0;
    end
    else
    begin
      if (term && !terminal)
      begin
        terminal  <= 1'b1;
        flush_cnt <= 6'd32;
      end

      // one extra cycle after the last flush shift before done rises
      if (terminal && flush_cnt == 6'd0)
        done <= 1'b1;

      if (shift_en)
      begin
        crc_reg <= {crc_reg[30:0], shift_bit} ^ feedback;
        if (terminal)
          flush_cnt <= flush_cnt - 6'd1;
      end
    end
  end

endmodule

//--- src/apb_host_regs.sv
`timescale 1ns/100ps

module apb_host_regs
  import eth_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [7:0]            paddr,
  input  logic [31:0]           pwdata,
  output logic [31:0]           prdata,
  output logic                  pready,
  output logic                  pslverr,
  output tx_req_t               tx_req,
  input  logic [word_idx_w-1:0] word_addr,
  output logic [31:0]           word_data,
  input  tx_status_t            tx_stat,
  input  rx_status_t            rx_stat,
  output logic                  irq
);

  logic [31:0]      words [max_words];
  logic             tx_done_f;
  logic             tx_abandoned_f;
  logic             rx_done_f;
  logic             rx_crc_ok_f;
  logic [len_w-1:0] rx_len_q;
  logic             access;
  logic             busy;
  logic             hit_ctrl;
  logic             hit_status;
  logic             hit_rx_len;
  logic             hit_data;
  logic [len_w-1:0] wr_len;
  logic             len_bad;
  logic             err;
  logic             start_ok;
  logic             wr_status;
  logic             wr_data;

  // the start pulse counts as busy so a back-to-back CTRL write is refused
  assign busy       = tx_stat.busy || tx_req.start;
  assign access     = psel && penable;
  assign hit_ctrl   = paddr == addr_ctrl;
  assign hit_status = paddr == addr_status;
  assign hit_rx_len = paddr == addr_rx_len;
  assign hit_data   = (paddr[7:6] == addr_data_base[7:6]) && (paddr[1:0] == 2'b00);

  assign wr_len  = pwdata[8:4];
  assign len_bad = (wr_len == '0) || (wr_len > len_w'(max_words));
  assign err     = !(hit_ctrl || hit_status || hit_rx_len || hit_data)
                   || (pwrite && busy && (hit_ctrl || hit_data))
                   || (pwrite && hit_ctrl && pwdata[0] && len_bad);

  assign pready    = 1'b1;
  assign pslverr   = access && err;
  assign start_ok  = access && pwrite && hit_ctrl && pwdata[0] && !err;
  assign wr_status = access && pwrite && hit_status;
  assign wr_data   = access && pwrite && hit_data && !err;

  assign word_data = words[word_addr];
  assign irq       = tx_done_f || tx_abandoned_f || rx_done_f;

  always_comb
  begin
    prdata = 32'h0;
    if (hit_ctrl)
      prdata = {23'h0, tx_req.len_words, 4'h0};
    else if (hit_status)
      prdata = {19'h0, tx_stat.attempts, 3'h0, rx_crc_ok_f, rx_done_f,
                tx_abandoned_f, tx_done_f, busy};
    else if (hit_rx_len)
      prdata = {27'h0, rx_len_q};
    else if (hit_data)
      prdata = words[paddr[5:2]];
  end

  always_ff @(posedge CLK)
  begin
    if (wr_data)
      words[paddr[5:2]] <= pwdata;
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      tx_req         <= '0;
      tx_done_f      <= 1'b0;
      tx_abandoned_f <= 1'b0;
      rx_done_f      <= 1'b0;
      rx_crc_ok_f    <= 1'b0;
      rx_len_q       <= '0;
    end
    else
    begin
      tx_req.start <= start_ok;
      if (start_ok)
        tx_req.len_words <= wr_len;

      // a new event wins over a clear in the same cycle
      if (tx_stat.done)
        tx_done_f <= 1'b1;
      else if (wr_status && pwdata[1])
        tx_done_f <= 1'b0;

      if (tx_stat.abandoned)
        tx_abandoned_f <= 1'b1;
      else if (wr_status && pwdata[2])
        tx_abandoned_f <= 1'b0;

      if (rx_stat.done)
      begin
        rx_done_f   <= 1'b1;
        rx_crc_ok_f <= rx_stat.crc_ok;
        rx_len_q    <= rx_stat.len_words;
      end
      else if (wr_status && pwdata[3])
        rx_done_f <= 1'b0;
    end
  end

endmodule

//--- src/medium_arbiter.sv
`timescale 1ns/100ps

module medium_arbiter
  import eth_pkg::*;
(
  input  logic             CLK,
  input  logic             RST,
  input  logic             carrier,
  input  logic             col,
  input  logic             medium_req,
  input  logic             tx_active,
  output logic             grant,
  output logic             abort,
  output logic             give_up,
  output logic [att_w-1:0] attempts
);

  logic [ifg_w-1:0]         cool_cnt;
  logic                     cool;
  logic [backoff_w-1:0]     bo_cnt;
  logic                     bo_active;
  logic [15:0]              lfsr;
  logic                     req_q;
  logic [att_w-1:0]         att_next;
  logic [att_w-1:0]         exp_sel;
  logic [backoff_limit-1:0] slot_mask;
  logic [backoff_limit-1:0] slot_cnt;

  // a collision only counts while our own frame is on the wire
  assign abort    = col && tx_active;
  assign cool     = cool_cnt == ifg_w'(ifg_cycles);
  assign att_next = attempts + 1'b1;
  assign exp_sel  = (att_next > att_w'(backoff_limit)) ? att_w'(backoff_limit) : att_next;

  // truncated binary exponential backoff, 2**exp_sel - 1 slots at most
  always_comb
  begin
    for (int i = 0; i < backoff_limit; i++)
      slot_mask[i] = i < int'(exp_sel);
    slot_cnt = lfsr[backoff_limit-1:0] & slot_mask;
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      lfsr      <= 16'hACE1;
      cool_cnt  <= '0;
      bo_cnt    <= '0;
      bo_active <= 1'b0;
      req_q     <= 1'b0;
      attempts  <= '0;
      grant     <= 1'b0;
      give_up   <= 1'b0;
    end
    else
    begin
      lfsr    <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      req_q   <= medium_req;
      grant   <= 1'b0;
      give_up <= 1'b0;

      // the gap restarts on any carrier, our own frame, or a pending backoff
      if (carrier || tx_active || bo_active)
        cool_cnt <= '0;
      else if (!cool)
        cool_cnt <= cool_cnt + 1'b1;

      // a fresh request belongs to a new frame
      if (medium_req && !req_q)
        attempts <= '0;

      if (abort)
      begin
        attempts <= att_next;
        if (att_next == att_w'(max_attempts))
          give_up <= 1'b1;
        else
        begin
          bo_active <= 1'b1;
          bo_cnt    <= backoff_w'(slot_cnt) * backoff_w'(slot_cycles);
        end
      end
      else if (bo_active)
      begin
        if (bo_cnt == '0)
          bo_active <= 1'b0;
        else
          bo_cnt <= bo_cnt - 1'b1;
      end
      else if (medium_req && cool && !grant && !tx_active)
        grant <= 1'b1;
    end
  end

endmodule

//--- src/tx_serializer.sv
`timescale 1ns/100ps

module tx_serializer
  import eth_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RST,
  input  tx_req_t               tx_req,
  input  logic [31:0]           word_data,
  input  logic                  grant,
  input  logic                  abort,
  input  logic                  give_up,
  output logic [word_idx_w-1:0] word_addr,
  output logic                  medium_req,
  output line_t                 tx,
  output tx_status_t            tx_stat
);

  typedef enum logic [2:0] {st_idle, st_calc, st_wait, st_send, st_fin} state_t;

  state_t               state;
  logic [len_w-1:0]     len_q;
  logic [bit_cnt_w-1:0] cnt;
  logic [bit_cnt_w-1:0] pay_bits;
  logic [bit_cnt_w-1:0] frame_bits;
  logic [31:0]          crc_q;
  logic                 first_word;
  logic                 next_bit;
  logic                 crc_rst;
  logic                 crc_write;
  logic                 crc_term;
  logic                 crc_done;
  logic [31:0]          crc_val;

  assign pay_bits   = {len_q, 5'b0};
  assign frame_bits = pay_bits + bit_cnt_w'(32);
  assign first_word = cnt[bit_cnt_w-1:5] == '0;
  assign word_addr  = cnt[word_idx_w+4:5];

  // cnt walks the payload MSB first, then the latched CRC
  assign next_bit = (cnt < pay_bits) ? word_data[~cnt[4:0]] : crc_q[~cnt[4:0]];

  // the engine restarts from zero for every frame, it is held clear while idle
  assign crc_rst   = RST && (state != st_idle);
  assign crc_write = (state == st_calc) && (cnt < pay_bits);
  assign crc_term  = crc_write && (cnt == pay_bits - 1'b1);

  assign medium_req = (state == st_wait) || (state == st_send)
                      || ((state == st_calc) && crc_done);

  assign tx_stat.busy     = state != st_idle;
  assign tx_stat.attempts = '0;

  crc32_engine crc_inst (
    .CLK    (CLK),
    .RST    (crc_rst),
    .bit_in (next_bit ^ first_word),
    .write  (crc_write),
    .term   (crc_term),
    .done   (crc_done),
    .crc    (crc_val)
  );

  always_ff @(posedge CLK)
  begin
    if (crc_done && state == st_calc)
      crc_q <= crc_val;
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state             <= st_idle;
      len_q             <= '0;
      cnt               <= '0;
      tx                <= '0;
      tx_stat.done      <= 1'b0;
      tx_stat.abandoned <= 1'b0;
    end
    else
    begin
      tx_stat.done      <= 1'b0;
      tx_stat.abandoned <= 1'b0;
      case (state)
        st_idle:
          if (tx_req.start)
          begin
            len_q <= tx_req.len_words;
            cnt   <= '0;
            state <= st_calc;
          end
        st_calc:
          if (crc_write)
            cnt <= cnt + 1'b1;
          else if (crc_done)
          begin
            cnt   <= '0;
            state <= st_wait;
          end
        st_wait:
          if (give_up)
          begin
            tx_stat.abandoned <= 1'b1;
            state             <= st_idle;
          end
          else if (grant)
          begin
            tx.data <= next_bit;
            tx.en   <= 1'b1;
            cnt     <= bit_cnt_w'(1);
            state   <= st_send;
          end
        st_send:
          // after a collision the whole frame goes out again from bit 0
          if (abort)
          begin
            tx.en <= 1'b0;
            cnt   <= '0;
            state <= st_wait;
          end
          else if (cnt == frame_bits)
          begin
            tx.en <= 1'b0;
            state <= st_fin;
          end
          else
          begin
            tx.data <= next_bit;
            cnt     <= cnt + 1'b1;
          end
        st_fin:
        begin
          tx_stat.done <= 1'b1;
          state        <= st_idle;
        end
        default:
          state <= st_idle;
      endcase
    end
  end

endmodule

//--- src/rx_crc_checker.sv
`timescale 1ns/100ps

module rx_crc_checker
  import eth_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,
  input  line_t      rx,
  output rx_status_t rx_stat
);

  logic [31:0]          hold;
  logic [bit_cnt_w-1:0] cnt;
  logic                 en_q;
  logic                 busy;
  logic                 first_word;
  logic                 eng_rst;
  logic                 eng_write;
  logic                 eng_term;
  logic                 eng_done;
  logic [31:0]          eng_crc;

  assign first_word = cnt[bit_cnt_w-1:5] == '0;

  // the engine only lives between the first bit and the verdict
  assign eng_rst   = RST && (rx.en || busy);
  // bits reach the engine once the hold-back register is full
  assign eng_write = rx.en && !first_word;
  assign eng_term  = en_q && !rx.en;

  // the last 32 bits still in the hold-back register are the received CRC
  assign rx_stat.done      = busy && !rx.en && eng_done;
  assign rx_stat.crc_ok    = hold == eng_crc;
  assign rx_stat.len_words = cnt[bit_cnt_w-1:5] - 1'b1;

  crc32_engine crc_inst (
    .CLK    (CLK),
    .RST    (eng_rst),
    .bit_in (hold[31]),
    .write  (eng_write),
    .term   (eng_term),
    .done   (eng_done),
    .crc    (eng_crc)
  );

  // first 32 bits are inverted on entry, which presets the augmented CRC
  always_ff @(posedge CLK)
  begin
    if (rx.en)
      hold <= {hold[30:0], rx.data ^ first_word};
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      en_q <= 1'b0;
      busy <= 1'b0;
      cnt  <= '0;
    end
    else
    begin
      en_q <= rx.en;
      if (rx.en)
      begin
        busy <= 1'b1;
        // saturate on oversized foreign frames
        if (cnt != '1)
          cnt <= cnt + 1'b1;
      end
      else if (rx_stat.done)
      begin
        busy <= 1'b0;
        cnt  <= '0;
      end
    end
  end

endmodule

//--- src/frame_engine_top.sv
`timescale 1ns/100ps

module frame_engine_top
  import eth_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  input  line_t       rx,
  input  logic        col,
  output line_t       tx,
  output logic        irq
);

  tx_req_t               tx_req;
  logic [word_idx_w-1:0] word_addr;
  logic [31:0]           word_data;
  tx_status_t            ser_stat;
  tx_status_t            tx_stat;
  rx_status_t            rx_stat;
  logic                  medium_req;
  logic                  grant;
  logic                  abort;
  logic                  give_up;
  logic [att_w-1:0]      attempts;

  // frame state comes from the serializer, the collision count from the arbiter
  assign tx_stat = '{busy: ser_stat.busy, done: ser_stat.done,
                     abandoned: ser_stat.abandoned, attempts: attempts};

  apb_host_regs apb_host_regs_inst (
    .CLK       (CLK),
    .RST       (RST),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .tx_req    (tx_req),
    .word_addr (word_addr),
    .word_data (word_data),
    .tx_stat   (tx_stat),
    .rx_stat   (rx_stat),
    .irq       (irq)
  );

  medium_arbiter medium_arbiter_inst (
    .CLK        (CLK),
    .RST        (RST),
    .carrier    (rx.en),
    .col        (col),
    .medium_req (medium_req),
    .tx_active  (tx.en),
    .grant      (grant),
    .abort      (abort),
    .give_up    (give_up),
    .attempts   (attempts)
  );

  tx_serializer tx_serializer_inst (
    .CLK        (CLK),
    .RST        (RST),
    .tx_req     (tx_req),
    .word_data  (word_data),
    .grant      (grant),
    .abort      (abort),
    .give_up    (give_up),
    .word_addr  (word_addr),
    .medium_req (medium_req),
    .tx         (tx),
    .tx_stat    (ser_stat)
  );

  rx_crc_checker rx_crc_checker_inst (
    .CLK     (CLK),
    .RST     (RST),
    .rx      (rx),
    .rx_stat (rx_stat)
  );

endmodule

//--- verif/frame_engine_tb.sv
`timescale 1ns/100ps

module frame_engine_tb
  import eth_pkg::*;
();

  // 40 frames of up to two passes of 17 words each plus arbitration slack
  localparam int timeout_cycles = 40 * (17 * 32 * 2 + 1200);

  logic        CLK;
  logic        RST;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  line_t       rx_line;
  logic        col;
  line_t       tx_line;
  logic        irq;

  logic [31:0] lfsr_state;
  logic [31:0] payload [max_words];
  int          errors;
  int          checks;
  int          cycle_cnt;

  // wire model controls and observations
  logic        loop_en;
  logic        foreign_en;
  logic        flip_en;
  int          flip_idx;
  int          col_upto;
  int          col_bit;
  int          attempt_no;
  int          last_len;
  int          rise_cycle;
  int          release_cycle;
  logic        tx_en_q;
  logic        col_q;
  logic        rec [$];

  frame_engine_top frame_engine_top_inst (
    .CLK     (CLK),
    .RST     (RST),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .rx      (rx_line),
    .col     (col),
    .tx      (tx_line),
    .irq     (irq)
  );

  initial
  begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], lfsr_step()};
    return v;
  endfunction

  // direct CRC-32 with an all-ones preset, MSB first and a final complement
  function automatic logic [31:0] ref_crc(input int len);
    logic [31:0] c;
    logic        fb;
    c = 32'hFFFFFFFF;
    for (int w = 0; w < len; w++)
    begin
      for (int b = 31; b >= 0; b--)
      begin
        fb = c[31] ^ payload[w][b];
        c  = {c[30:0], 1'b0} ^ (fb ? 32'h04C11DB7 : 32'h0);
      end
    end
    return ~c;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    @(posedge CLK);
    #2;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge CLK);
    #2;
    penable = 1'b1;
    #18;
    err = pslverr;
    check("pready", 32'(pready), 32'h1);
    @(posedge CLK);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    @(posedge CLK);
    #2;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge CLK);
    #2;
    penable = 1'b1;
    #18;
    data = prdata;
    err  = pslverr;
    check("pready", 32'(pready), 32'h1);
    @(posedge CLK);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic load_payload(input int len);
    logic err;
    for (int i = 0; i < len; i++)
    begin
      payload[i] = rand_bits(32);
      apb_write(addr_data_base + 8'(4 * i), payload[i], err);
      check("pslverr_data_load", 32'(err), 32'h0);
    end
  endtask

  task automatic start_tx(input int len);
    logic err;
    apb_write(addr_ctrl, (32'(len) << 4) | 32'h1, err);
    check("pslverr_start", 32'(err), 32'h0);
  endtask

  // polls STATUS until one of the bits in mask is set
  task automatic wait_status(input logic [31:0] mask, output logic [31:0] st);
    logic err;
    st = '0;
    while ((st & mask) == 32'h0)
      apb_read(addr_status, st, err);
  endtask

  task automatic clear_status();
    logic err;
    apb_write(addr_status, 32'h0000000E, err);
  endtask

  // the last recorded attempt must be the payload followed by its CRC
  task automatic check_frame(input int len);
    logic [31:0] got;
    logic [31:0] exp;
    @(posedge CLK);
    check("tx_en_cycles", 32'(last_len), 32'((len + 1) * 32));
    if (last_len == (len + 1) * 32)
    begin
      for (int w = 0; w <= len; w++)
      begin
        for (int b = 0; b < 32; b++)
          got = {got[30:0], rec[w * 32 + b]};
        exp = (w < len) ? payload[w] : ref_crc(len);
        check($sformatf("tx_word[%0d]", w), got, exp);
      end
    end
  endtask

  always @(posedge CLK)
  begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles)
    begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("checks: %0d, errors: %0d", checks, errors);
      $display("TEST FAILED");
      $finish;
    end
  end

  // the wire model samples tx after the edge and drives rx and col for the next one
  always @(posedge CLK)
  begin
    #2;
    if (col_q)
      check("tx_en_after_col", 32'(tx_line.en), 32'h0);
    col_q = 1'b0;
    col   = 1'b0;
    if (tx_line.en)
    begin
      if (!tx_en_q)
      begin
        attempt_no++;
        rise_cycle = cycle_cnt;
        rec.delete();
      end
      rec.push_back(tx_line.data);
      if (attempt_no <= col_upto && rec.size() == col_bit + 1)
      begin
        col   = 1'b1;
        col_q = 1'b1;
      end
    end
    else if (tx_en_q)
      last_len = rec.size();
    tx_en_q = tx_line.en;
    if (loop_en)
    begin
      rx_line.en   = tx_line.en;
      rx_line.data = tx_line.data ^ (flip_en && tx_line.en && rec.size() == flip_idx + 1);
    end
    else
    begin
      if (rx_line.en && !foreign_en)
        release_cycle = cycle_cnt;
      rx_line.en   = foreign_en;
      rx_line.data = 1'b0;
    end
  end

  initial
  begin
    logic [31:0] st;
    logic [31:0] rd;
    logic [31:0] base;
    logic        err;
    int          len;
    int          start_att;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = 8'h0;
    pwdata        = 32'h0;
    rx_line       = '0;
    col           = 1'b0;
    RST           = 1'b0;
    lfsr_state    = 32'h5435;
    errors        = 0;
    checks        = 0;
    cycle_cnt     = 0;
    loop_en       = 1'b0;
    foreign_en    = 1'b0;
    flip_en       = 1'b0;
    flip_idx      = 0;
    col_upto      = 0;
    col_bit       = 0;
    attempt_no    = 0;
    last_len      = 0;
    rise_cycle    = 0;
    release_cycle = 0;
    tx_en_q       = 1'b0;
    col_q         = 1'b0;

    repeat (3) @(posedge CLK);
    #2;
    RST = 1'b1;
    check("irq_after_reset", 32'(irq), 32'h0);
    check("tx_en_after_reset", 32'(tx_line.en), 32'h0);
    apb_read(addr_status, st, err);
    check("status_after_reset", st, 32'h0);

    // random frames on an idle line
    for (int n = 0; n < 8; n++)
    begin
      len = int'(rand_bits(4)) + 1;
      load_payload(len);
      start_tx(len);
      wait_status(32'h6, st);
      check("tx_done", 32'(st[1]), 32'h1);
      check("irq_on_tx_done", 32'(irq), 32'h1);
      check_frame(len);
      clear_status();
      check("irq_cleared", 32'(irq), 32'h0);
    end

    // loopback of a clean frame and then of one with a flipped bit
    @(posedge CLK);
    loop_en = 1'b1;
    len = int'(rand_bits(4)) + 1;
    load_payload(len);
    start_tx(len);
    wait_status(32'h8, st);
    check("rx_crc_ok", 32'(st[4]), 32'h1);
    apb_read(addr_rx_len, rd, err);
    check("rx_len", rd, 32'(len));
    check_frame(len);
    clear_status();
    @(posedge CLK);
    flip_en  = 1'b1;
    flip_idx = 7;
    start_tx(len);
    wait_status(32'h8, st);
    check("rx_crc_ok_flipped", 32'(st[4]), 32'h0);
    clear_status();
    @(posedge CLK);
    loop_en = 1'b0;
    flip_en = 1'b0;

    // a foreign carrier holds the frame back until the gap has passed
    @(posedge CLK);
    foreign_en = 1'b1;
    start_att  = attempt_no;
    load_payload(1);
    start_tx(1);
    repeat (150) @(posedge CLK);
    check("tx_en_under_carrier", 32'(attempt_no), 32'(start_att));
    foreign_en = 1'b0;
    wait_status(32'h6, st);
    check_frame(1);
    check("ifg_gap_ok", 32'((rise_cycle - release_cycle) >= ifg_cycles), 32'h1);
    clear_status();

    // two collisions are followed by a clean retry
    @(posedge CLK);
    attempt_no = 0;
    col_upto   = 2;
    col_bit    = 40;
    len = int'(rand_bits(4)) + 1;
    load_payload(len);
    start_tx(len);
    wait_status(32'h6, st);
    check("tx_done_after_retry", 32'(st[1]), 32'h1);
    check("attempts_after_retry", 32'(st[12:8]), 32'h2);
    check("attempts_on_wire", 32'(attempt_no), 32'h3);
    check_frame(len);
    clear_status();

    // every attempt collides until the frame is dropped
    @(posedge CLK);
    attempt_no = 0;
    col_upto   = 1000;
    col_bit    = 5;
    load_payload(2);
    start_tx(2);
    wait_status(32'h6, st);
    check("tx_abandoned", 32'(st[2]), 32'h1);
    check("tx_done_on_abandon", 32'(st[1]), 32'h0);
    check("attempts_on_abandon", 32'(st[12:8]), 32'(max_attempts));
    check("abandon_attempts_on_wire", 32'(attempt_no), 32'(max_attempts));
    check("irq_on_abandon", 32'(irq), 32'h1);
    clear_status();
    check("irq_cleared_abandon", 32'(irq), 32'h0);
    @(posedge CLK);
    col_upto = 0;

    // APB error responses
    apb_read(addr_status, base, err);
    apb_write(8'h10, 32'hFFFFFFFF, err);
    check("pslverr_unmapped_wr", 32'(err), 32'h1);
    apb_read(8'h0C, rd, err);
    check("pslverr_unmapped_rd", 32'(err), 32'h1);
    apb_write(addr_ctrl, 32'h00000001, err);
    check("pslverr_len_0", 32'(err), 32'h1);
    apb_write(addr_ctrl, (32'd17 << 4) | 32'h1, err);
    check("pslverr_len_17", 32'(err), 32'h1);
    apb_read(addr_status, st, err);
    check("status_after_errors", st, base);
    load_payload(2);
    start_tx(2);
    apb_write(addr_data_base, ~payload[0], err);
    check("pslverr_busy_data", 32'(err), 32'h1);
    apb_write(addr_ctrl, (32'd1 << 4) | 32'h1, err);
    check("pslverr_busy_ctrl", 32'(err), 32'h1);
    apb_read(addr_data_base, rd, err);
    check("data_word_kept", rd, payload[0]);
    wait_status(32'h2, st);
    check_frame(2);
    check("irq_before_w1c", 32'(irq), 32'h1);
    apb_write(addr_status, 32'h00000002, err);
    check("irq_after_w1c", 32'(irq), 32'h0);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- build.f
src/eth_pkg.sv
src/crc32_engine.sv
src/apb_host_regs.sv
src/medium_arbiter.sv
src/tx_serializer.sv
src/rx_crc_checker.sv
src/frame_engine_top.sv
verif/frame_engine_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= frame_engine_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

# build and run, then decide the result from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
